/* src/async_fifo_pkg.sv */
package async_fifo_pkg;

  // ----------------------------------------
  // Pointer helpers
  // ----------------------------------------
  localparam int PTR_MAX_W = 16;  // Widest pointer the helpers handle

  // Write side status
  typedef struct packed {
    logic full;
    logic afull;
  } wr_flags_t;

  // Read side status
  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_flags_t;

  // Binary to reflected Gray
  function automatic logic [PTR_MAX_W-1:0] bin2gray(
    input logic [PTR_MAX_W-1:0] bin
  );
    return (bin >> 1) ^ bin;
  endfunction

  // Gray back to binary, MSB first
  function automatic logic [PTR_MAX_W-1:0] gray2bin(
    input logic [PTR_MAX_W-1:0] gray
  );
    logic [PTR_MAX_W-1:0] bin;
    bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
    for (int i = PTR_MAX_W-2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];  // Running xor of the upper bits
    end
    return bin;
  endfunction

  // Upper bits above the caller's pointer width stay zero,
  // so both helpers give the right low bits for any narrower
  // pointer padded with zeros

endpackage

/* src/fifo_dpram.sv */
`timescale 1ns/1ps

module fifo_dpram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];  // Word storage

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------
  // Output register holds the last word read until the next taken read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];  // Valid one rd_clk later
    end
  end

  // Controllers never let the two ports hit the same slot at once,
  // since an unread slot is never written and an unwritten slot never read

endmodule

/* src/gray_ptr_sync.sv */
`timescale 1ns/1ps

module gray_ptr_sync #(
  parameter int PTR_W = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [PTR_W-1:0] gray_in,
  output logic [PTR_W-1:0] bin_out
);

  logic [PTR_W-1:0] sync_q1;  // First stage, may go metastable
  logic [PTR_W-1:0] sync_q2;  // Settled Gray value

  logic [async_fifo_pkg::PTR_MAX_W-1:0] gray_ext;
  logic [async_fifo_pkg::PTR_MAX_W-1:0] bin_ext;

  // ----------------------------------------
  // Two flop synchronizer
  // ----------------------------------------
  // Only one bit of gray_in moves per source edge, so any sampled
  // value is either the old or the new pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // ----------------------------------------
  // Gray to binary
  // ----------------------------------------
  always_comb begin
    gray_ext = '0;
    gray_ext[PTR_W-1:0] = sync_q2;  // Zero pad to helper width
    bin_ext = async_fifo_pkg::gray2bin(gray_ext);
  end

  assign bin_out = bin_ext[PTR_W-1:0];

  // Conversion after the second stage adds no flop, so the pointer
  // reaches the controller two or three edges after the source moved
  // depending on clock phase

endmodule

/* src/fifo_wr_ctrl.sv */
`timescale 1ns/1ps

module fifo_wr_ctrl #(
  parameter int ADDR_WIDTH = 4,
  parameter int FIFO_AFULL = 14
) (
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      wr_en,
  input  logic [ADDR_WIDTH:0]       rd_ptr_bin,   // Read pointer, already in wr_clk
  output logic                      ram_we,
  output logic [ADDR_WIDTH-1:0]     ram_waddr,
  output logic [ADDR_WIDTH:0]       wr_gray,
  output async_fifo_pkg::wr_flags_t wr_flags,
  output logic [ADDR_WIDTH:0]       wr_used
);

  localparam int PTR_W = ADDR_WIDTH + 1;
  localparam logic [PTR_W-1:0] DEPTH     = PTR_W'(1 << ADDR_WIDTH);
  localparam logic [PTR_W-1:0] AFULL_LVL = PTR_W'(FIFO_AFULL);

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] used_nxt;

  logic [async_fifo_pkg::PTR_MAX_W-1:0] ptr_ext;
  logic [async_fifo_pkg::PTR_MAX_W-1:0] gray_ext;

  // ----------------------------------------
  // Next pointer
  // ----------------------------------------
  assign ram_we    = wr_en & ~wr_flags.full;  // Drop writes while full
  assign ram_waddr = wr_ptr[ADDR_WIDTH-1:0];

  always_comb begin
    if (ram_we) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  always_comb begin
    ptr_ext = '0;
    ptr_ext[PTR_W-1:0] = wr_ptr_nxt;
    gray_ext = async_fifo_pkg::bin2gray(ptr_ext);
  end

  // Wrap bit makes the subtraction give DEPTH when the FIFO is full
  assign used_nxt = wr_ptr_nxt - rd_ptr_bin;

  // ----------------------------------------
  // Pointer and flag registers
  // ----------------------------------------
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr   <= '0;
      wr_gray  <= '0;
      wr_used  <= '0;
      wr_flags <= '{full: 1'b0, afull: 1'b0};
    end else begin
      wr_ptr         <= wr_ptr_nxt;
      wr_gray        <= gray_ext[PTR_W-1:0];  // Registered before crossing
      wr_used        <= used_nxt;
      wr_flags.full  <= (used_nxt == DEPTH);  // Rises with the last free slot
      wr_flags.afull <= (used_nxt >= AFULL_LVL);
    end
  end

  // The read pointer seen here lags the real one, so used count
  // and both flags err on the full side and never allow an overwrite

endmodule

/* src/fifo_rd_ctrl.sv */
`timescale 1ns/1ps

module fifo_rd_ctrl #(
  parameter int ADDR_WIDTH  = 4,
  parameter int FIFO_AEMPTY = 2
) (
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,
  input  logic                      rd_en,
  input  logic [ADDR_WIDTH:0]       wr_ptr_bin,   // Write pointer, already in rd_clk
  output logic                      ram_re,
  output logic [ADDR_WIDTH-1:0]     ram_raddr,
  output logic [ADDR_WIDTH:0]       rd_gray,
  output async_fifo_pkg::rd_flags_t rd_flags,
  output logic [ADDR_WIDTH:0]       rd_level
);

  localparam int PTR_W = ADDR_WIDTH + 1;
  localparam logic [PTR_W-1:0] AEMPTY_LVL = PTR_W'(FIFO_AEMPTY);

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic [PTR_W-1:0] level_nxt;

  logic [async_fifo_pkg::PTR_MAX_W-1:0] ptr_ext;
  logic [async_fifo_pkg::PTR_MAX_W-1:0] gray_ext;

  // ----------------------------------------
  // Next pointer
  // ----------------------------------------
  assign ram_re    = rd_en & ~rd_flags.empty;  // Ignore reads while empty
  assign ram_raddr = rd_ptr[ADDR_WIDTH-1:0];

  always_comb begin
    if (ram_re) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  always_comb begin
    ptr_ext = '0;
    ptr_ext[PTR_W-1:0] = rd_ptr_nxt;
    gray_ext = async_fifo_pkg::bin2gray(ptr_ext);
  end

  // Words still available after this edge
  assign level_nxt = wr_ptr_bin - rd_ptr_nxt;

  // ----------------------------------------
  // Pointer and flag registers
  // ----------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr   <= '0;
      rd_gray  <= '0;
      rd_level <= '0;
      rd_flags <= '{empty: 1'b1, aempty: 1'b1};
    end else begin
      rd_ptr          <= rd_ptr_nxt;
      rd_gray         <= gray_ext[PTR_W-1:0];
      rd_level        <= level_nxt;
      rd_flags.empty  <= (level_nxt == '0);  // Rises with the last read
      rd_flags.aempty <= (level_nxt <= AEMPTY_LVL);
    end
  end

  // The synchronized write pointer trails the writer, so a fresh
  // word shows up here a few rd_clk edges late and empty stays
  // high until then, never the other way round

endmodule

/* src/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,               // Power of two
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 2
) (
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      wr_en,
  input  logic [DATA_WIDTH-1:0]     wr_data,
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,
  input  logic                      rd_en,
  output logic [DATA_WIDTH-1:0]     rd_data,
  output async_fifo_pkg::wr_flags_t wr_flags,
  output async_fifo_pkg::rd_flags_t rd_flags,
  output logic [$clog2(FIFO_DEPTH):0] wr_used,
  output logic [$clog2(FIFO_DEPTH):0] rd_level
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  ram_we;
  logic [ADDR_WIDTH-1:0] ram_waddr;
  logic                  ram_re;
  logic [ADDR_WIDTH-1:0] ram_raddr;
  logic [ADDR_WIDTH:0]   wr_gray;
  logic [ADDR_WIDTH:0]   rd_gray;
  logic [ADDR_WIDTH:0]   wr_ptr_sync;  // Write pointer in rd_clk
  logic [ADDR_WIDTH:0]   rd_ptr_sync;  // Read pointer in wr_clk

  // ----------------------------------------
  // Write domain
  // ----------------------------------------
  fifo_wr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) wr_ctrl_i (
    .wr_clk     (wr_clk),
    .wr_rst_n   (wr_rst_n),
    .wr_en      (wr_en),
    .rd_ptr_bin (rd_ptr_sync),
    .ram_we     (ram_we),
    .ram_waddr  (ram_waddr),
    .wr_gray    (wr_gray),
    .wr_flags   (wr_flags),
    .wr_used    (wr_used)
  );

  gray_ptr_sync #(
    .PTR_W (ADDR_WIDTH + 1)
  ) rd2wr_sync_i (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_sync)
  );

  // ----------------------------------------
  // Read domain
  // ----------------------------------------
  fifo_rd_ctrl #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) rd_ctrl_i (
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .rd_en      (rd_en),
    .wr_ptr_bin (wr_ptr_sync),
    .ram_re     (ram_re),
    .ram_raddr  (ram_raddr),
    .rd_gray    (rd_gray),
    .rd_flags   (rd_flags),
    .rd_level   (rd_level)
  );

  gray_ptr_sync #(
    .PTR_W (ADDR_WIDTH + 1)
  ) wr2rd_sync_i (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_sync)
  );

  // Storage spans both domains
  fifo_dpram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram_i (
    .wr_clk   (wr_clk),
    .wr_en    (ram_we),
    .wr_addr  (ram_waddr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (ram_re),
    .rd_addr  (ram_raddr),
    .rd_data  (rd_data)
  );

endmodule

/* verification/async_fifo_tb.sv */
`timescale 1ns/1ps

module async_fifo_tb;

  localparam int DATA_WIDTH  = 8;
  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_AFULL  = FIFO_DEPTH - 2;
  localparam int FIFO_AEMPTY = 2;
  localparam int AW          = $clog2(FIFO_DEPTH);

  localparam int OP_WRITE = 0;
  localparam int OP_READ  = 1;
  localparam int OP_BOTH  = 2;
  localparam int OP_IDLE  = 3;

  logic                      rd_clk = 1'b0;
  logic                      wr_clk = 1'b0;
  logic                      wr_rst_n;
  logic                      rd_rst_n;
  logic                      wr_en;
  logic [DATA_WIDTH-1:0]     wr_data;
  logic                      rd_en;
  logic [DATA_WIDTH-1:0]     rd_data;
  async_fifo_pkg::wr_flags_t wr_flags;
  async_fifo_pkg::rd_flags_t rd_flags;
  logic [AW:0]               wr_used;
  logic [AW:0]               rd_level;

  logic [DATA_WIDTH-1:0] ref_q[$];   // Accepted words not yet read
  logic [DATA_WIDTH-1:0] held_data;  // What rd_data should show now
  int                    case_op[$];
  int                    case_count[$];
  logic [DATA_WIDTH-1:0] case_seed[$];
  int                    total_count = 0;
  int                    cycle_count = 0;
  int                    cycle_limit = 200;

  always #2 rd_clk = ~rd_clk;  // 4 ns
  always #3 wr_clk = ~wr_clk;  // 6 ns, the slower clock

  async_fifo dut_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .wr_flags (wr_flags),
    .rd_flags (rd_flags),
    .wr_used  (wr_used),
    .rd_level (rd_level)
  );

  // ----------------------------------------
  // Reporting
  // ----------------------------------------
  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s actual 0x%0h expected 0x%0h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  always @(posedge rd_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run($sformatf("Run did not finish within %0d rd_clk cycles", cycle_limit));
    end
  end

  // ----------------------------------------
  // Case file
  // ----------------------------------------
  task automatic load_cases();
    int                    fd;
    int                    n;
    string                 line;
    logic [8*8-1:0]        op_name;
    int                    cnt;
    logic [DATA_WIDTH-1:0] seed;
    fd = $fopen("verification/async_fifo_cases.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open verification/async_fifo_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %d %h", op_name, cnt, seed);
        if (n != 3) begin
          abort_run($sformatf("Malformed line in cases file: %s", line));
        end
        if (op_name == "WRITE") case_op.push_back(OP_WRITE);
        else if (op_name == "READ") case_op.push_back(OP_READ);
        else if (op_name == "BOTH") case_op.push_back(OP_BOTH);
        else if (op_name == "IDLE") case_op.push_back(OP_IDLE);
        else abort_run($sformatf("Unknown operation in cases file: %s", line));
        case_count.push_back(cnt);
        case_seed.push_back(seed);
        total_count = total_count + cnt;
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // Write and read sides
  // ----------------------------------------
  task automatic write_words(input int count, input logic [DATA_WIDTH-1:0] seed,
                             input bit random_en);
    int                    i;
    bit                    en;
    logic [DATA_WIDTH-1:0] word;
    for (i = 0; i < count; i++) begin
      @(posedge wr_clk);
      #1;
      if (ref_q.size() == FIFO_DEPTH) begin
        compare_value("wr_flags.full", wr_flags.full, 1'b1);  // No room left
      end
      en = !random_en || ($urandom % 2 == 1);
      word = seed + i[DATA_WIDTH-1:0];
      wr_en = en;
      wr_data = word;
      if (en && !wr_flags.full) begin
        ref_q.push_back(word);  // Accepted at the coming edge
      end
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic read_words(input int count, input bit random_en);
    int                    i;
    bit                    en;
    bit                    pending;
    logic [DATA_WIDTH-1:0] exp_word;
    pending = 1'b0;
    exp_word = '0;
    for (i = 0; i <= count; i++) begin
      @(posedge rd_clk);
      #1;
      if (pending) begin
        held_data = exp_word;
      end
      compare_value("rd_data", rd_data, held_data);
      if (ref_q.size() == 0) begin
        compare_value("rd_flags.empty", rd_flags.empty, 1'b1);
      end
      pending = 1'b0;
      en = (i < count) && (!random_en || ($urandom % 2 == 1));
      rd_en = en;
      if (en && !rd_flags.empty) begin
        exp_word = ref_q.pop_front();
        pending = 1'b1;
      end
    end
    rd_en = 1'b0;
  endtask

  // Let both pointers settle, then flags and levels must match the queue
  task automatic idle_check(input int count);
    int n;
    repeat (count) @(posedge wr_clk);
    #1;
    n = ref_q.size();
    compare_value("wr_used", wr_used, n);
    compare_value("rd_level", rd_level, n);
    compare_value("wr_flags.full", wr_flags.full, n == FIFO_DEPTH);
    compare_value("wr_flags.afull", wr_flags.afull, n >= FIFO_AFULL);
    compare_value("rd_flags.empty", rd_flags.empty, n == 0);
    compare_value("rd_flags.aempty", rd_flags.aempty, n <= FIFO_AEMPTY);
    compare_value("rd_data", rd_data, held_data);
  endtask

  task automatic check_reset_state();
    compare_value("rd_flags.empty", rd_flags.empty, 1'b1);
    compare_value("rd_flags.aempty", rd_flags.aempty, 1'b1);
    compare_value("wr_flags.full", wr_flags.full, 1'b0);
    compare_value("wr_flags.afull", wr_flags.afull, 1'b0);
    compare_value("wr_used", wr_used, 0);
    compare_value("rd_level", rd_level, 0);
    compare_value("rd_data", rd_data, 0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int k;
    void'($urandom(15));
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en = 1'b0;
    wr_data = '0;
    rd_en = 1'b0;
    held_data = '0;
    load_cases();
    cycle_limit = 20 * total_count + 200;

    repeat (2) @(posedge wr_clk);
    @(posedge rd_clk);
    #1;
    rd_rst_n = 1'b1;  // Release away from any rd_clk edge
    @(posedge wr_clk);
    #1;
    wr_rst_n = 1'b1;
    check_reset_state();

    for (k = 0; k < case_op.size(); k++) begin
      case (case_op[k])
        OP_WRITE: write_words(case_count[k], case_seed[k], 1'b0);
        OP_READ:  read_words(case_count[k], 1'b0);
        OP_BOTH: begin
          fork
            write_words(case_count[k], case_seed[k], 1'b1);
            read_words(case_count[k], 1'b1);
          join
        end
        default:  idle_check(case_count[k]);
      endcase
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* verification/async_fifo_cases.txt */
# Columns: operation (WRITE, READ, BOTH, IDLE), count in cycles, data seed in hex
# IDLE counts wr_clk cycles and then checks flags and levels against the queue
IDLE   8    00
WRITE  1    a5
IDLE   8    00
READ   2    00
IDLE   8    00
READ   3    00
IDLE   8    00
WRITE  3    10
IDLE   8    00
WRITE  2    20
IDLE   8    00
READ   8    00
IDLE   8    00
WRITE  14   30
IDLE   8    00
WRITE  6    40
IDLE   8    00
READ   20   00
IDLE   8    00
WRITE  20   60
IDLE   8    00
WRITE  4    80
IDLE   8    00
READ   14   00
IDLE   8    00
READ   6    00
IDLE   8    00
BOTH   80   90
IDLE   8    00
READ   20   00
IDLE   8    00
WRITE  12   c0
BOTH   120  d0
IDLE   8    00
READ   20   00
IDLE   8    00
BOTH   60   f0
IDLE   8    00
READ   20   00
IDLE   10   00

/* async_fifo.f */
src/async_fifo_pkg.sv
src/fifo_dpram.sv
src/gray_ptr_sync.sv
src/fifo_wr_ctrl.sv
src/fifo_rd_ctrl.sv
src/async_fifo.sv
verification/async_fifo_tb.sv

/* Bender.yml */
package:
  name: async_fifo

dependencies: {}

sources:
  # Design
  - src/async_fifo_pkg.sv
  - src/fifo_dpram.sv
  - src/gray_ptr_sync.sv
  - src/fifo_wr_ctrl.sv
  - src/fifo_rd_ctrl.sv
  - src/async_fifo.sv

  # Testbench
  - target: test
    files:
      - verification/async_fifo_tb.sv

# Simulation top: async_fifo_tb
# Design top: async_fifo
